// ==== src/fsab_pkg.sv ====
package fsab_pkg;

	// Request mode, one bit on the bus
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_req_e;

	typedef logic [4:0]  fsab_did_t;   // Device id and sub-id
	typedef logic [30:0] fsab_addr_t;  // Word address
	typedef logic [2:0]  fsab_len_t;   // Burst length in beats
	typedef logic [63:0] fsab_data_t;
	typedef logic [7:0]  fsab_mask_t;  // One bit per byte lane

	// Requests a master may have in flight
	localparam int FSAB_INITIAL_CREDITS = 4;

	// Longest write burst
	localparam int FSAB_LEN_MAX = 4;

	// Data FIFO sized for every outstanding request at full length
	localparam int FSAB_DFIF_DEPTH = FSAB_INITIAL_CREDITS * FSAB_LEN_MAX;

	// Credit count and request FIFO pointer, extra bit for wrap
	typedef logic [2:0] fsab_credit_t;

	// Data FIFO pointer, 16 entries plus wrap bit
	typedef logic [4:0] fsab_dptr_t;

	// Arbiter FSM
	typedef enum logic [1:0] {
		ARB_IDLE,   // Looking for a nonempty FIFO
		ARB_START,  // start_trans held to the granted FIFO
		ARB_BUSY    // Granted FIFO driving the bus
	} arb_state_e;

endpackage

// ==== src/fsab_req_if.sv ====
`timescale 1ns/1ps

// One request bus, master side or memory side of an arbiter FIFO
interface fsab_req_if import fsab_pkg::*; ();

	logic       valid;   // One beat this cycle
	fsab_req_e  mode;
	fsab_did_t  did;
	fsab_did_t  subdid;
	fsab_addr_t addr;
	fsab_len_t  len;     // Beats in the whole request
	fsab_data_t data;    // Meaningless on a read
	fsab_mask_t mask;

	// Driver side
	modport source (
		output valid,
		output mode,
		output did,
		output subdid,
		output addr,
		output len,
		output data,
		output mask
	);

	// Receiver side
	modport sink (
		input valid,
		input mode,
		input did,
		input subdid,
		input addr,
		input len,
		input data,
		input mask
	);

endinterface

// ==== src/fsab_gray_sync.sv ====
`timescale 1ns/1ps

// Counter crossing, Gray coded so only one bit moves per step
module fsab_gray_sync #(
	parameter int WIDTH = 3
) (
	input  logic             src_clk,
	input  logic             src_rst_b,
	input  logic             oclk_dst,
	input  logic             dst_rst_b,
	input  logic [WIDTH-1:0] count_next,
	output logic [WIDTH-1:0] gray_dst
);

	logic [WIDTH-1:0] gray_src;  // Launch flop, no comb logic after it
	logic [WIDTH-1:0] gray_s1;   // First stage, may go metastable

	// Order matters: convert, flop in source, then two far-side flops
	always_ff @(posedge src_clk or negedge src_rst_b) begin
		if (!src_rst_b) begin
			gray_src <= '0;
		end else begin
			gray_src <= count_next ^ (count_next >> 1);
		end
	end

	always_ff @(posedge oclk_dst or negedge dst_rst_b) begin
		if (!dst_rst_b) begin
			gray_s1  <= '0;
			gray_dst <= '0;
		end else begin
			gray_s1  <= gray_src;
			gray_dst <= gray_s1;  // Settled value
		end
	end

endmodule

// ==== src/fsab_arbiter_fifo.sv ====
`timescale 1ns/1ps

module fsab_arbiter_fifo import fsab_pkg::*; (
	input  logic       iclk,
	input  logic       iclk_rst_b,
	input  logic       oclk,
	input  logic       oclk_rst_b,
	fsab_req_if.sink   inp,
	output logic       inp_credit,
	fsab_req_if.source out,
	output logic       empty_b,      // oclk
	input  logic       start_trans,  // oclk
	output logic       active        // oclk
);

	localparam int RFIF_AW = $clog2(FSAB_INITIAL_CREDITS);
	localparam int DFIF_AW = $clog2(FSAB_DFIF_DEPTH);

	// Header entry
	typedef struct packed {
		fsab_req_e  mode;
		fsab_did_t  did;
		fsab_did_t  subdid;
		fsab_addr_t addr;
		fsab_len_t  len;
	} rfif_word_t;

	// Data entry
	typedef struct packed {
		fsab_data_t data;
		fsab_mask_t mask;
	} dfif_word_t;

	logic         credit_oclk;        // One credit freed this cycle
	fsab_credit_t credits_oclk;
	fsab_credit_t credits_oclk_next;
	fsab_credit_t credits_iclk;       // Credits already handed back
	fsab_credit_t credits_g_iclk;     // oclk count, Gray, in iclk

	fsab_len_t    inp_rem;            // Write beats still due, plus one
	logic         inp_hdr;

	rfif_word_t   rfif_mem [FSAB_INITIAL_CREDITS];
	logic         rfif_wr;
	logic         rfif_rd;
	logic         rfif_empty;
	fsab_credit_t rfif_wpos;
	fsab_credit_t rfif_wpos_next;
	fsab_credit_t rfif_rpos;
	fsab_credit_t rfif_wpos_g_oclk;
	rfif_word_t   rfif_rdat;          // Header of current transaction

	dfif_word_t   dfif_mem [FSAB_DFIF_DEPTH];
	logic         dfif_wr;
	logic         dfif_rd;
	logic         dfif_empty;
	fsab_dptr_t   dfif_wpos;
	fsab_dptr_t   dfif_wpos_next;
	fsab_dptr_t   dfif_rpos;
	fsab_dptr_t   dfif_wpos_g_oclk;
	dfif_word_t   dfif_rdat;

	fsab_len_t    mem_rem;            // Data words still to pop, first one included
	logic         mem_act;            // Write draining
	logic         mem_act_d;
	logic         rfif_rd_d;
	logic         dfif_rd_d;

	// Credit return, oclk counts and iclk catches up one step per cycle
	assign credits_oclk_next = credits_oclk + fsab_credit_t'(credit_oclk);
	assign inp_credit = credits_g_iclk != (credits_iclk ^ (credits_iclk >> 1));

	fsab_gray_sync #(
		.WIDTH($bits(fsab_credit_t))
	) credit_sync_i (
		.src_clk   (oclk),
		.src_rst_b (oclk_rst_b),
		.oclk_dst  (iclk),
		.dst_rst_b (iclk_rst_b),
		.count_next(credits_oclk_next),
		.gray_dst  (credits_g_iclk)
	);

	// Only the first beat of a request goes into the header FIFO
	assign inp_hdr        = inp.valid && (inp_rem <= fsab_len_t'(1));
	assign rfif_wr        = inp_hdr;
	assign dfif_wr        = inp.valid;  // Every beat, read beats too
	assign rfif_wpos_next = rfif_wpos + fsab_credit_t'(rfif_wr);
	assign dfif_wpos_next = dfif_wpos + fsab_dptr_t'(dfif_wr);

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			credits_iclk <= '0;
			inp_rem      <= '0;
			rfif_wpos    <= '0;
			dfif_wpos    <= '0;
		end else begin
			if (inp_credit)
				credits_iclk <= credits_iclk + 1'b1;
			if (inp_hdr && inp.mode == FSAB_WRITE)
				inp_rem <= inp.len;
			else if (inp.valid && inp_rem != '0)
				inp_rem <= inp_rem - 1'b1;
			rfif_wpos <= rfif_wpos_next;
			dfif_wpos <= dfif_wpos_next;
		end
	end

	// Storage written on iclk
	always_ff @(posedge iclk) begin
		if (rfif_wr)
			rfif_mem[rfif_wpos[RFIF_AW-1:0]] <= {inp.mode, inp.did, inp.subdid, inp.addr, inp.len};
		if (dfif_wr)
			dfif_mem[dfif_wpos[DFIF_AW-1:0]] <= {inp.data, inp.mask};
	end

	fsab_gray_sync #(
		.WIDTH($bits(fsab_credit_t))
	) rfif_wpos_sync_i (
		.src_clk   (iclk),
		.src_rst_b (iclk_rst_b),
		.oclk_dst  (oclk),
		.dst_rst_b (oclk_rst_b),
		.count_next(rfif_wpos_next),
		.gray_dst  (rfif_wpos_g_oclk)
	);

	fsab_gray_sync #(
		.WIDTH($bits(fsab_dptr_t))
	) dfif_wpos_sync_i (
		.src_clk   (iclk),
		.src_rst_b (iclk_rst_b),
		.oclk_dst  (oclk),
		.dst_rst_b (oclk_rst_b),
		.count_next(dfif_wpos_next),
		.gray_dst  (dfif_wpos_g_oclk)
	);

	// Write side lags, so empty may linger but never clears early
	assign rfif_empty = (rfif_rpos ^ (rfif_rpos >> 1)) == rfif_wpos_g_oclk;
	assign dfif_empty = (dfif_rpos ^ (dfif_rpos >> 1)) == dfif_wpos_g_oclk;
	assign empty_b    = !rfif_empty;

	// Busy from header pop until the last write beat has left
	assign active  = rfif_rd_d || mem_act || mem_act_d;
	assign rfif_rd = start_trans && !active;  // Arbiter only grants a nonempty FIFO
	assign dfif_rd = rfif_rd ||               // First word pops with the header
		(mem_act && mem_rem > fsab_len_t'(1) && !dfif_empty);

	// Write credit once draining ends, read credit right after the pop
	assign credit_oclk = (mem_act_d && !mem_act) ||
		(rfif_rd_d && rfif_rdat.mode == FSAB_READ);

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			credits_oclk <= '0;
			rfif_rpos    <= '0;
			dfif_rpos    <= '0;
			rfif_rd_d    <= 1'b0;
			dfif_rd_d    <= 1'b0;
			mem_act      <= 1'b0;
			mem_act_d    <= 1'b0;
			mem_rem      <= '0;
		end else begin
			credits_oclk <= credits_oclk_next;
			rfif_rpos    <= rfif_rpos + fsab_credit_t'(rfif_rd);
			dfif_rpos    <= dfif_rpos + fsab_dptr_t'(dfif_rd);
			rfif_rd_d    <= rfif_rd;
			dfif_rd_d    <= dfif_rd;
			mem_act_d    <= mem_act;
			if (rfif_rd_d && rfif_rdat.mode == FSAB_WRITE) begin
				mem_act <= 1'b1;  // Header just landed
				mem_rem <= rfif_rdat.len;
			end else if (mem_act && dfif_rd) begin
				mem_rem <= mem_rem - 1'b1;
			end else if (mem_rem <= fsab_len_t'(1)) begin
				mem_act <= 1'b0;
			end
		end
	end

	// Read ports, data lands one cycle after the pop
	always_ff @(posedge oclk) begin
		if (rfif_rd)
			rfif_rdat <= rfif_mem[rfif_rpos[RFIF_AW-1:0]];
		if (dfif_rd)
			dfif_rdat <= dfif_mem[dfif_rpos[DFIF_AW-1:0]];
	end

	assign out.valid  = dfif_rd_d;
	assign out.mode   = rfif_rdat.mode;
	assign out.did    = rfif_rdat.did;
	assign out.subdid = rfif_rdat.subdid;
	assign out.addr   = rfif_rdat.addr;
	assign out.len    = rfif_rdat.len;
	assign out.data   = dfif_rdat.data;
	assign out.mask   = dfif_rdat.mask;

	// Grant must never land on an empty header FIFO
	a_rfif_rd_nonempty: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		rfif_rd |-> !rfif_empty)
		else $error("rfif read while empty");

	// Header and its first data word cross together
	a_dfif_rd_nonempty: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		dfif_rd |-> !dfif_empty)
		else $error("dfif read while empty");

	// Master must hold a credit for every header
	a_rfif_wr_notfull: assert property (@(posedge iclk) disable iff (!iclk_rst_b)
		rfif_wr |-> (rfif_wpos - credits_iclk) != fsab_credit_t'(FSAB_INITIAL_CREDITS))
		else $error("rfif write while full");

endmodule

// ==== src/fsab_arbiter.sv ====
`timescale 1ns/1ps

module fsab_arbiter import fsab_pkg::*; #(
	parameter int NUM_MASTERS = 2
) (
	input  logic                   oclk,
	input  logic                   oclk_rst_b,
	input  logic [NUM_MASTERS-1:0] empty_b,
	input  logic [NUM_MASTERS-1:0] active,
	output logic [NUM_MASTERS-1:0] start_trans,
	fsab_req_if.sink               req [NUM_MASTERS],
	output logic                   out_valid,
	output fsab_req_e              out_mode,
	output fsab_did_t              out_did,
	output fsab_did_t              out_subdid,
	output fsab_addr_t             out_addr,
	output fsab_len_t              out_len,
	output fsab_data_t             out_data,
	output fsab_mask_t             out_mask
);

	localparam int GW = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

	arb_state_e    state;
	logic [GW-1:0] grant;       // Current, or last, owner of the bus
	logic [GW-1:0] next_grant;

	// Flattened copies of the FIFO buses for variable indexing
	logic       valid_a  [NUM_MASTERS];
	fsab_req_e  mode_a   [NUM_MASTERS];
	fsab_did_t  did_a    [NUM_MASTERS];
	fsab_did_t  subdid_a [NUM_MASTERS];
	fsab_addr_t addr_a   [NUM_MASTERS];
	fsab_len_t  len_a    [NUM_MASTERS];
	fsab_data_t data_a   [NUM_MASTERS];
	fsab_mask_t mask_a   [NUM_MASTERS];

	for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_req
		assign valid_a[i]  = req[i].valid;
		assign mode_a[i]   = req[i].mode;
		assign did_a[i]    = req[i].did;
		assign subdid_a[i] = req[i].subdid;
		assign addr_a[i]   = req[i].addr;
		assign len_a[i]    = req[i].len;
		assign data_a[i]   = req[i].data;
		assign mask_a[i]   = req[i].mask;
	end

	// Round robin, scan down so the nearest one after grant wins
	always_comb begin : pick
		int unsigned idx;
		next_grant = grant;
		for (int k = NUM_MASTERS; k >= 1; k--) begin
			idx = (int'(grant) + k) % NUM_MASTERS;
			if (empty_b[idx])
				next_grant = GW'(idx);
		end
	end

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			state <= ARB_IDLE;
			grant <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (|empty_b) begin
						state <= ARB_START;
						grant <= next_grant;
					end
				end
				ARB_START: if (active[grant]) state <= ARB_BUSY;   // Header popped
				ARB_BUSY:  if (!active[grant]) state <= ARB_IDLE;  // Last beat gone
				default:   state <= ARB_IDLE;
			endcase
		end
	end

	always_comb begin
		start_trans = '0;
		if (state == ARB_START)
			start_trans[grant] = 1'b1;
	end

	// Only the granted FIFO can have valid high
	assign out_valid  = valid_a[grant];
	assign out_mode   = mode_a[grant];
	assign out_did    = did_a[grant];
	assign out_subdid = subdid_a[grant];
	assign out_addr   = addr_a[grant];
	assign out_len    = len_a[grant];
	assign out_data   = data_a[grant];
	assign out_mask   = mask_a[grant];

	// Grant lands on one FIFO, one with a header waiting or already popped
	a_start_onehot: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		start_trans != '0 |-> $onehot(start_trans & (empty_b | active)))
		else $error("start_trans not one-hot to a FIFO with work");

	// Two FIFOs busy at once would mean interleaved transactions
	a_active_onehot: assert property (@(posedge oclk) disable iff (!oclk_rst_b)
		$onehot0(active))
		else $error("more than one FIFO active");

endmodule

// ==== src/fsab_arbiter_top.sv ====
`timescale 1ns/1ps

module fsab_arbiter_top import fsab_pkg::*; #(
	parameter int NUM_MASTERS = 2
) (
	input  logic                         iclk,
	input  logic                         iclk_rst_b,
	input  logic                         oclk,
	input  logic                         oclk_rst_b,
	input  logic       [NUM_MASTERS-1:0] inp_valid,
	input  fsab_req_e  [NUM_MASTERS-1:0] inp_mode,
	input  fsab_did_t  [NUM_MASTERS-1:0] inp_did,
	input  fsab_did_t  [NUM_MASTERS-1:0] inp_subdid,
	input  fsab_addr_t [NUM_MASTERS-1:0] inp_addr,
	input  fsab_len_t  [NUM_MASTERS-1:0] inp_len,
	input  fsab_data_t [NUM_MASTERS-1:0] inp_data,
	input  fsab_mask_t [NUM_MASTERS-1:0] inp_mask,
	output logic       [NUM_MASTERS-1:0] inp_credit,
	output logic                         out_valid,
	output fsab_req_e                    out_mode,
	output fsab_did_t                    out_did,
	output fsab_did_t                    out_subdid,
	output fsab_addr_t                   out_addr,
	output fsab_len_t                    out_len,
	output fsab_data_t                   out_data,
	output fsab_mask_t                   out_mask
);

	logic [NUM_MASTERS-1:0] empty_b;
	logic [NUM_MASTERS-1:0] start_trans;
	logic [NUM_MASTERS-1:0] active;

	fsab_req_if inp_bus [NUM_MASTERS] ();  // Master side, iclk
	fsab_req_if arb_bus [NUM_MASTERS] ();  // FIFO to arbiter, oclk

	for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
		assign inp_bus[i].valid  = inp_valid[i];
		assign inp_bus[i].mode   = inp_mode[i];
		assign inp_bus[i].did    = inp_did[i];
		assign inp_bus[i].subdid = inp_subdid[i];
		assign inp_bus[i].addr   = inp_addr[i];
		assign inp_bus[i].len    = inp_len[i];
		assign inp_bus[i].data   = inp_data[i];
		assign inp_bus[i].mask   = inp_mask[i];

		fsab_arbiter_fifo fsab_arbiter_fifo_i (
			.iclk       (iclk),
			.iclk_rst_b (iclk_rst_b),
			.oclk       (oclk),
			.oclk_rst_b (oclk_rst_b),
			.inp        (inp_bus[i].sink),
			.inp_credit (inp_credit[i]),
			.out        (arb_bus[i].source),
			.empty_b    (empty_b[i]),
			.start_trans(start_trans[i]),
			.active     (active[i])
		);
	end

	fsab_arbiter #(
		.NUM_MASTERS(NUM_MASTERS)
	) fsab_arbiter_i (
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.empty_b    (empty_b),
		.active     (active),
		.start_trans(start_trans),
		.req        (arb_bus),
		.out_valid  (out_valid),
		.out_mode   (out_mode),
		.out_did    (out_did),
		.out_subdid (out_subdid),
		.out_addr   (out_addr),
		.out_len    (out_len),
		.out_data   (out_data),
		.out_mask   (out_mask)
	);

endmodule

// ==== verif/fsab_arbiter_tb.sv ====
`timescale 1ns/1ps

module fsab_arbiter_tb import fsab_pkg::*; ();

	localparam int NM  = 2;
	localparam int TMO = 2000;  // Cycles per wait loop

	// One request as read from the stimulus file
	typedef struct packed {
		fsab_req_e  mode;
		fsab_did_t  did;
		fsab_did_t  subdid;
		fsab_addr_t addr;
		fsab_len_t  len;
		logic [31:0] seed;  // Bit k set means an idle cycle after beat k
	} req_t;

	typedef struct packed {
		fsab_data_t data;
		fsab_mask_t mask;
	} beat_t;

	logic oclk;
	logic iclk;
	logic oclk_rst_b;
	logic iclk_rst_b;

	logic       [NM-1:0] inp_valid;
	fsab_req_e  [NM-1:0] inp_mode;
	fsab_did_t  [NM-1:0] inp_did;
	fsab_did_t  [NM-1:0] inp_subdid;
	fsab_addr_t [NM-1:0] inp_addr;
	fsab_len_t  [NM-1:0] inp_len;
	fsab_data_t [NM-1:0] inp_data;
	fsab_mask_t [NM-1:0] inp_mask;
	logic       [NM-1:0] inp_credit;

	logic       out_valid;
	fsab_req_e  out_mode;
	fsab_did_t  out_did;
	fsab_did_t  out_subdid;
	fsab_addr_t out_addr;
	fsab_len_t  out_len;
	fsab_data_t out_data;
	fsab_mask_t out_mask;

	req_t  drv_q [NM][$];  // Still to drive
	req_t  exp_q [NM][$];  // Still to appear on the output
	beat_t drv_b [NM][$];
	beat_t exp_b [NM][$];  // Write beats only
	time   issue_t [NM][$];  // Header drive time of unseen requests

	int credits [NM];
	int issued [NM];
	int returned [NM];
	int did_master [32];
	int errs [1:5];
	int n_pass;
	int n_fail;
	int last_master;
	bit in_trans;
	req_t cur;
	int cur_m;
	int beats;

	fsab_arbiter_top #(
		.NUM_MASTERS(NM)
	) fsab_arbiter_top_i (
		.iclk      (iclk),
		.iclk_rst_b(iclk_rst_b),
		.oclk      (oclk),
		.oclk_rst_b(oclk_rst_b),
		.inp_valid (inp_valid),
		.inp_mode  (inp_mode),
		.inp_did   (inp_did),
		.inp_subdid(inp_subdid),
		.inp_addr  (inp_addr),
		.inp_len   (inp_len),
		.inp_data  (inp_data),
		.inp_mask  (inp_mask),
		.inp_credit(inp_credit),
		.out_valid (out_valid),
		.out_mode  (out_mode),
		.out_did   (out_did),
		.out_subdid(out_subdid),
		.out_addr  (out_addr),
		.out_len   (out_len),
		.out_data  (out_data),
		.out_mask  (out_mask)
	);

	initial begin
		oclk = 1'b0;
		forever #2 oclk = ~oclk;  // 4 ns
	end

	initial begin
		iclk = 1'b0;
		forever #3 iclk = ~iclk;  // 6 ns, master side
	end

	task automatic mismatch(int bhv, string name, logic [63:0] exp, logic [63:0] act);
		$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
		errs[bhv]++;
	endtask

	task automatic problem(int bhv, string what);
		$display("Error at %0t: %s", $time, what);
		errs[bhv]++;
	endtask

	task automatic abort_run(string what);
		$display("Run stopped at %0t: %s", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic print_behavior(int bhv, string name);
		if (errs[bhv] == 0) begin
			n_pass++;
			$display("Behavior %0d, %s: ok", bhv, name);
		end else begin
			n_fail++;
			$display("Behavior %0d, %s: %0d errors", bhv, name, errs[bhv]);
		end
	endtask

	// Requests and their data beats, data built from the line's seed
	task automatic read_stimulus();
		int fd;
		string line;
		int m;
		int mode;
		int did;
		int subdid;
		int len;
		int n;
		logic [31:0] addr;
		logic [31:0] seed;
		req_t r;
		beat_t b;
		fd = $fopen("verif/fsab_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open verif/fsab_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 4 || line[0] == 8'h23)
					continue;  // Blank or comment
				if ($sscanf(line, "%h %h %h %h %h %h %h", m, mode, did, subdid, addr, len,
						seed) != 7)
					continue;
				r.mode   = fsab_req_e'(mode[0]);
				r.did    = fsab_did_t'(did);
				r.subdid = fsab_did_t'(subdid);
				r.addr   = fsab_addr_t'(addr);
				r.len    = fsab_len_t'(len);
				r.seed   = seed;
				drv_q[m].push_back(r);
				exp_q[m].push_back(r);
				did_master[did] = m;
				n = (r.mode == FSAB_WRITE) ? len : 1;  // Read still sends one beat
				for (int k = 0; k < n; k++) begin
					b.data = {$urandom, $urandom} ^ {seed, seed};
					b.mask = fsab_mask_t'($urandom ^ seed);
					drv_b[m].push_back(b);
					if (r.mode == FSAB_WRITE)
						exp_b[m].push_back(b);
				end
			end
			$fclose(fd);
		end
	endtask

	// One master, one request per credit, beats on falling iclk
	task automatic drive_master(int m);
		req_t r;
		beat_t b;
		int n;
		int cnt;
		@(posedge iclk);
		@(negedge iclk);  // First beat on a falling iclk edge
		while (drv_q[m].size() > 0) begin
			r = drv_q[m].pop_front();
			cnt = 0;
			while (credits[m] == 0 && cnt < TMO) begin
				@(negedge iclk);
				cnt++;
			end
			if (cnt >= TMO) begin
				abort_run($sformatf("master %0d got no credit", m));
			end else begin
				credits[m]--;
				issued[m]++;
				n = (r.mode == FSAB_WRITE) ? int'(r.len) : 1;
				for (int k = 0; k < n; k++) begin
					b = drv_b[m].pop_front();
					inp_valid[m]  = 1'b1;
					inp_mode[m]   = r.mode;
					inp_did[m]    = r.did;
					inp_subdid[m] = r.subdid;
					inp_addr[m]   = r.addr;
					inp_len[m]    = r.len;
					inp_data[m]   = b.data;
					inp_mask[m]   = b.mask;
					if (k == 0)
						issue_t[m].push_back($time);
					@(negedge iclk);
					inp_valid[m] = 1'b0;
					if (r.seed[k])
						@(negedge iclk);  // Gap inside the write
				end
			end
		end
	endtask

	// Credit pulses, counted at the iclk edge the DUT counts them on
	initial begin
		forever begin
			@(posedge iclk);
			for (int m = 0; m < NM; m++) begin
				if (iclk_rst_b && inp_credit[m]) begin
					credits[m]++;
					returned[m]++;
					if (credits[m] > FSAB_INITIAL_CREDITS)
						problem(4, $sformatf("master %0d got a credit it never spent", m));
				end
			end
		end
	end

	task automatic watch_beat();
		req_t hd;
		beat_t b;
		int m;
		int o;
		int bhv;
		if (!in_trans) begin
			m = did_master[out_did];
			if (m < 0 || exp_q[m].size() == 0) begin
				problem(5, $sformatf("unexpected transaction from did %h", out_did));
				return;
			end
			hd  = exp_q[m].pop_front();
			bhv = (hd.mode == FSAB_WRITE) ? 2 : 3;
			if (out_mode !== hd.mode)
				mismatch(bhv, "out_mode", hd.mode, out_mode);
			if (out_subdid !== hd.subdid)
				mismatch(bhv, "out_subdid", hd.subdid, out_subdid);
			if (out_addr !== hd.addr)
				mismatch(bhv, "out_addr", hd.addr, out_addr);
			if (out_len !== hd.len)
				mismatch(bhv, "out_len", hd.len, out_len);
			o = 1 - m;
			// Other master long since queued, so round robin owed it the bus
			if (last_master == m && issue_t[o].size() > 0 && issue_t[o][0] + 100 < $time)
				problem(5, $sformatf("master %0d granted twice while master %0d waited", m, o));
			void'(issue_t[m].pop_front());
			cur      = hd;
			cur_m    = m;
			beats    = 0;
			in_trans = 1'b1;
		end
		if (out_did !== cur.did)
			mismatch(5, "out_did", cur.did, out_did);  // Interleaved
		if (out_addr !== cur.addr)
			mismatch(5, "out_addr", cur.addr, out_addr);
		if (cur.mode == FSAB_WRITE) begin
			if (exp_b[cur_m].size() == 0) begin
				problem(2, "write beat beyond the expected data");
			end else begin
				b = exp_b[cur_m].pop_front();
				if (out_data !== b.data)
					mismatch(2, "out_data", b.data, out_data);
				if (out_mask !== b.mask)
					mismatch(2, "out_mask", b.mask, out_mask);
			end
		end
		beats++;
		if (beats >= ((cur.mode == FSAB_WRITE) ? int'(cur.len) : 1)) begin
			in_trans    = 1'b0;
			last_master = cur_m;
		end
	endtask

	// Outputs settle after the rising edge, sampled mid cycle
	initial begin
		forever begin
			@(negedge oclk);
			if (oclk_rst_b && out_valid)
				watch_beat();
		end
	end

	initial begin
		int cnt;
		inp_valid   = '0;
		inp_mode    = {NM{FSAB_READ}};
		inp_did     = '0;
		inp_subdid  = '0;
		inp_addr    = '0;
		inp_len     = '0;
		inp_data    = '0;
		inp_mask    = '0;
		oclk_rst_b  = 1'b0;
		iclk_rst_b  = 1'b0;
		n_pass      = 0;
		n_fail      = 0;
		last_master = -1;
		in_trans    = 1'b0;
		for (int i = 1; i <= 5; i++)
			errs[i] = 0;
		for (int i = 0; i < 32; i++)
			did_master[i] = -1;
		for (int m = 0; m < NM; m++) begin
			credits[m]  = FSAB_INITIAL_CREDITS;
			issued[m]   = 0;
			returned[m] = 0;
		end
		void'($urandom(32'h0439_52ea));
		read_stimulus();

		repeat (10) @(posedge oclk);
		@(negedge oclk);
		oclk_rst_b = 1'b1;
		iclk_rst_b = 1'b1;

		// Quiet bus before any request
		repeat (20) begin
			@(negedge oclk);
			if (out_valid !== 1'b0)
				mismatch(1, "out_valid", 0, out_valid);
			if (inp_credit !== '0)
				mismatch(1, "inp_credit", 0, inp_credit);
		end
		print_behavior(1, "idle after reset");

		fork
			drive_master(0);
			drive_master(1);
		join

		cnt = 0;
		while ((exp_q[0].size() > 0 || exp_q[1].size() > 0 || in_trans) && cnt < TMO) begin
			@(negedge oclk);
			cnt++;
		end
		if (cnt >= TMO) begin
			abort_run("transactions still outstanding");
		end else begin
			// Last credits may still be crossing back
			cnt = 0;
			while ((credits[0] != FSAB_INITIAL_CREDITS || credits[1] != FSAB_INITIAL_CREDITS) &&
					cnt < TMO) begin
				@(negedge iclk);
				cnt++;
			end
			if (cnt >= TMO)
				problem(4, "credits did not all come back");

			for (int m = 0; m < NM; m++) begin
				if (returned[m] != issued[m])
					mismatch(4, $sformatf("master %0d credits", m), issued[m], returned[m]);
			end
			print_behavior(2, "write beats and data");
			print_behavior(3, "read beat");
			print_behavior(4, "credit count");
			print_behavior(5, "order and round robin");
			$display("Behaviors passed %0d, failed %0d", n_pass, n_fail);
			if (n_fail == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== verif/fsab_stimulus.txt ====
# master mode did subdid addr len seed, all hex
# mode 1 writes len beats, mode 0 is a one-beat read; seed bit k adds a gap after beat k
0 1 01 00 00001000 1 00000000
0 1 01 03 00001010 4 00000005
0 0 01 01 00001020 1 00000000
0 1 01 02 00001030 2 00000002
0 1 01 04 00001040 3 00000000
0 0 01 05 00001050 1 00000001
0 1 01 06 00001060 4 00000008
0 1 01 07 00001070 1 00000000
0 0 01 08 00001080 1 00000000
0 1 01 09 00001090 2 00000001
0 1 01 0a 000010a0 4 00000000
1 0 02 00 00002000 1 00000000
1 1 02 01 00002010 3 00000004
1 1 02 02 00002020 4 00000000
1 0 02 03 00002030 1 00000000
1 1 02 04 00002040 1 00000000
1 1 02 05 00002050 2 00000003
1 0 02 06 00002060 1 00000000
1 1 02 07 00002070 4 0000000a
1 1 02 08 00002080 3 00000000
1 0 02 09 00002090 1 00000000
1 1 02 0a 000020a0 2 00000000

// ==== all.f ====
src/fsab_pkg.sv
src/fsab_req_if.sv
src/fsab_gray_sync.sv
src/fsab_arbiter_fifo.sv
src/fsab_arbiter.sv
src/fsab_arbiter_top.sv
verif/fsab_arbiter_tb.sv

// ==== Bender.yml ====
package:
  name: fsab_arbiter

sources:
  - src/fsab_pkg.sv
  - src/fsab_req_if.sv
  - src/fsab_gray_sync.sv
  - src/fsab_arbiter_fifo.sv
  - src/fsab_arbiter.sv
  - src/fsab_arbiter_top.sv
  - target: test
    files:
      - verif/fsab_arbiter_tb.sv
